/* rv_isa_pkg.sv */
package rv_isa_pkg;

  // ==============================
  // Machine widths
  // ==============================

  localparam int XLEN = 32;

  // Data word, also used for addresses
  typedef logic [XLEN-1:0] xlen_t;

  // Architectural register index
  typedef logic [4:0] reg_idx_t;

  // Load/store width and signedness field
  typedef logic [2:0] funct3_t;

  // One enable per byte lane
  typedef logic [XLEN/8-1:0] wstrb_t;

  // ==============================
  // Load/store size in funct3[1:0]
  // ==============================

  localparam logic [1:0] SIZE_BYTE = 2'b00;
  localparam logic [1:0] SIZE_HALF = 2'b01;
  localparam logic [1:0] SIZE_WORD = 2'b10;

  // Set for LBU and LHU
  localparam int LD_UNSIGNED_BIT = 2;

endpackage

/* rv_pipe_pkg.sv */
package rv_pipe_pkg;

  // Source of the stage result seen by forwarding and WB
  typedef enum logic [1:0] {
    RES_ALU = 2'd0,
    RES_PC4 = 2'd1,
    RES_TGT = 2'd2
  } res_src_e;

  // Trap cause carried down the pipe
  typedef enum logic [1:0] {
    TRAP_NONE          = 2'd0,
    TRAP_ILLEGAL       = 2'd1,
    TRAP_LDST_MISALIGN = 2'd2
  } trap_code_e;

endpackage

/* rv_wb_if.sv */
interface rv_wb_if;

  // Control bits, cleared by a bubble in the MEM/WB register
  logic                    reg_write;
  logic                    trap;

  // Payload, allowed to go stale
  rv_pipe_pkg::trap_code_e trap_code;
  rv_isa_pkg::reg_idx_t    rd;
  rv_pipe_pkg::res_src_e   res_src;
  rv_isa_pkg::funct3_t     funct3;
  rv_isa_pkg::xlen_t       alu_result;
  rv_isa_pkg::xlen_t       pc_plus4;
  rv_isa_pkg::xlen_t       jb_tgt;
  rv_isa_pkg::xlen_t       ld_data;

  // Stage side
  modport src(
    output reg_write, trap, trap_code, rd, res_src, funct3,
    output alu_result, pc_plus4, jb_tgt, ld_data
  );

  // MEM/WB register side
  modport sink(
    input reg_write, trap, trap_code, rd, res_src, funct3,
    input alu_result, pc_plus4, jb_tgt, ld_data
  );

endinterface

/* rv_st_fmt.sv */
module rv_st_fmt (
  input  rv_isa_pkg::xlen_t   rs2_data_i,
  input  logic [1:0]          addr_lo_i,
  input  rv_isa_pkg::funct3_t funct3_i,
  output rv_isa_pkg::xlen_t   wdata_o,
  output rv_isa_pkg::wstrb_t  wstrb_o
);

  // Signedness bit is irrelevant for stores
  logic [1:0] size;

  assign size = funct3_i[1:0];

  // Memory picks the lane by strobe, so data is copied to every lane
  always_comb begin
    case (size)
      rv_isa_pkg::SIZE_BYTE: begin
        wdata_o = {4{rs2_data_i[7:0]}};
        // One lane at the byte offset
        wstrb_o = 4'b0001 << addr_lo_i;
      end
      rv_isa_pkg::SIZE_HALF: begin
        wdata_o = {2{rs2_data_i[15:0]}};
        // Upper or lower pair, bit 0 is checked for alignment elsewhere
        wstrb_o = addr_lo_i[1] ? 4'b1100 : 4'b0011;
      end
      default: begin
        // SW and the unused size code write the whole word
        wdata_o = rs2_data_i;
        wstrb_o = 4'b1111;
      end
    endcase
  end

endmodule

/* rv_ld_fmt.sv */
module rv_ld_fmt (
  input  rv_isa_pkg::xlen_t   rdata_i,
  input  logic [1:0]          addr_lo_i,
  input  rv_isa_pkg::funct3_t funct3_i,
  output rv_isa_pkg::xlen_t   data_o
);

  logic [7:0]  ld_byte;
  logic [15:0] ld_half;
  logic        ld_unsigned;

  // Byte lane chosen by the offset
  always_comb begin
    case (addr_lo_i)
      2'd0:    ld_byte = rdata_i[7:0];
      2'd1:    ld_byte = rdata_i[15:8];
      2'd2:    ld_byte = rdata_i[23:16];
      default: ld_byte = rdata_i[31:24];
    endcase
  end

  // Halfword lane, offset bit 0 ignored
  assign ld_half     = addr_lo_i[1] ? rdata_i[31:16] : rdata_i[15:0];
  assign ld_unsigned = funct3_i[rv_isa_pkg::LD_UNSIGNED_BIT];

  // Extend to a full word
  always_comb begin
    case (funct3_i[1:0])
      rv_isa_pkg::SIZE_BYTE:
        data_o = {{24{!ld_unsigned && ld_byte[7]}}, ld_byte};
      rv_isa_pkg::SIZE_HALF:
        data_o = {{16{!ld_unsigned && ld_half[15]}}, ld_half};
      default:
        data_o = rdata_i;
    endcase
  end

endmodule

/* rv_dmem_port.sv */
module rv_dmem_port (
  input  logic                    valid_i,
  input  logic                    mem_read_i,
  input  logic                    mem_write_i,
  input  logic                    reg_write_i,
  input  logic                    trap_i,
  input  rv_pipe_pkg::trap_code_e trap_code_i,
  input  rv_isa_pkg::funct3_t     funct3_i,
  input  rv_isa_pkg::xlen_t       addr_i,
  input  rv_isa_pkg::xlen_t       rs2_data_i,
  output logic                    dmem_ren_o,
  output logic                    dmem_we_o,
  output rv_isa_pkg::xlen_t       dmem_raddr_o,
  output rv_isa_pkg::xlen_t       dmem_waddr_o,
  output rv_isa_pkg::xlen_t       dmem_wdata_o,
  output rv_isa_pkg::wstrb_t      dmem_wstrb_o,
  rv_wb_if.src                    wb
);

  logic               misalign;
  logic               trap;
  rv_isa_pkg::wstrb_t st_wstrb;

  // ==============================
  // Store formatting
  // ==============================

  rv_st_fmt rv_st_fmt_i (
    .rs2_data_i(rs2_data_i),
    .addr_lo_i (addr_i[1:0]),
    .funct3_i  (funct3_i),
    .wdata_o   (dmem_wdata_o),
    .wstrb_o   (st_wstrb)
  );

  // ==============================
  // Misalignment and trap merge
  // ==============================

  // Only a real load or store can be misaligned
  always_comb begin
    misalign = 1'b0;
    if (mem_read_i || mem_write_i) begin
      case (funct3_i[1:0])
        rv_isa_pkg::SIZE_HALF: misalign = addr_i[0];
        rv_isa_pkg::SIZE_WORD: misalign = |addr_i[1:0];
        default:               misalign = 1'b0;
      endcase
    end
  end

  // Trap from EX or from this stage
  assign trap = trap_i || misalign;

  // ==============================
  // Memory request
  // ==============================

  // A trapped access never reaches memory
  assign dmem_ren_o   = valid_i && mem_read_i && !trap;
  assign dmem_we_o    = valid_i && mem_write_i && !trap;
  // Memory is word addressed, lanes come from the strobes
  assign dmem_raddr_o = {addr_i[31:2], 2'b00};
  assign dmem_waddr_o = {addr_i[31:2], 2'b00};
  assign dmem_wstrb_o = mem_write_i ? st_wstrb : 4'b0000;

  // WB-bound control, a trap kills the register write
  assign wb.trap      = trap;
  assign wb.trap_code = misalign ? rv_pipe_pkg::TRAP_LDST_MISALIGN : trap_code_i;
  assign wb.reg_write = reg_write_i && !trap;

  // Request must only go out for accesses the formatter can place
  always_comb begin
    if (dmem_ren_o || dmem_we_o) begin
      a_aligned_access: assert (
        (funct3_i[1:0] == rv_isa_pkg::SIZE_BYTE) ||
        (funct3_i[1:0] == rv_isa_pkg::SIZE_HALF && !addr_i[0]) ||
        (funct3_i[1:0] == rv_isa_pkg::SIZE_WORD && addr_i[1:0] == 2'b00)
      );
    end
  end

endmodule

/* rv_mem_wb_reg.sv */
module rv_mem_wb_reg (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    valid_i,
  input  logic                    stall_i,
  rv_wb_if.sink                   wb,
  output logic                    valid_o,
  output logic                    reg_write_wb_o,
  output logic                    trap_wb_o,
  output rv_pipe_pkg::trap_code_e trap_code_wb_o,
  output rv_isa_pkg::reg_idx_t    rd_wb_o,
  output rv_pipe_pkg::res_src_e   res_src_wb_o,
  output rv_isa_pkg::funct3_t     funct3_wb_o,
  output rv_isa_pkg::xlen_t       alu_result_wb_o,
  output rv_isa_pkg::xlen_t       pc_plus4_wb_o,
  output rv_isa_pkg::xlen_t       jb_tgt_wb_o,
  output rv_isa_pkg::xlen_t       ld_data_wb_o
);

  // ==============================
  // Control, bubble on idle input
  // ==============================

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valid_o        <= 1'b0;
      reg_write_wb_o <= 1'b0;
      trap_wb_o      <= 1'b0;
    end else if (!stall_i) begin
      valid_o        <= valid_i;
      // WB acts on these directly, so they must be clean on a bubble
      reg_write_wb_o <= valid_i && wb.reg_write;
      trap_wb_o      <= valid_i && wb.trap;
    end
  end

  // ==============================
  // Payload, no bubble
  // ==============================

  always_ff @(posedge clk) begin
    if (!stall_i) begin
      trap_code_wb_o  <= wb.trap_code;
      rd_wb_o         <= wb.rd;
      res_src_wb_o    <= wb.res_src;
      funct3_wb_o     <= wb.funct3;
      alu_result_wb_o <= wb.alu_result;
      pc_plus4_wb_o   <= wb.pc_plus4;
      jb_tgt_wb_o     <= wb.jb_tgt;
      // Load data was formatted in MEM
      ld_data_wb_o    <= wb.ld_data;
    end
  end

  // An instruction held in WB must not vanish during back-pressure
  a_valid_hold: assert property (
    @(posedge clk) disable iff (!rst_n)
    (stall_i && valid_o) |=> valid_o
  );

  // Side-effect bits only travel with a valid instruction
  a_ctrl_needs_valid: assert property (
    @(posedge clk) disable iff (!rst_n)
    (reg_write_wb_o || trap_wb_o) |-> valid_o
  );

endmodule

/* rv_stage_mem.sv */
module rv_stage_mem (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    valid_i,
  input  logic                    stall_i,
  input  logic                    reg_write_i,
  input  logic                    mem_read_i,
  input  logic                    mem_write_i,
  input  logic                    trap_i,
  input  rv_pipe_pkg::trap_code_e trap_code_i,
  input  rv_pipe_pkg::res_src_e   res_src_i,
  input  rv_isa_pkg::funct3_t     funct3_i,
  input  rv_isa_pkg::reg_idx_t    rd_i,
  input  rv_isa_pkg::xlen_t       alu_result_i,
  input  rv_isa_pkg::xlen_t       rs2_data_i,
  input  rv_isa_pkg::xlen_t       pc_plus4_i,
  input  rv_isa_pkg::xlen_t       jb_tgt_i,
  // Data memory, answers in the same cycle
  output logic                    dmem_ren_o,
  output rv_isa_pkg::xlen_t       dmem_raddr_o,
  input  rv_isa_pkg::xlen_t       dmem_rdata_i,
  output logic                    dmem_we_o,
  output rv_isa_pkg::xlen_t       dmem_waddr_o,
  output rv_isa_pkg::xlen_t       dmem_wdata_o,
  output rv_isa_pkg::wstrb_t      dmem_wstrb_o,
  // Forwarding
  output rv_isa_pkg::xlen_t       result_mem_o,
  output rv_isa_pkg::xlen_t       ld_data_mem_o,
  // WB stage
  output logic                    valid_o,
  output logic                    reg_write_wb_o,
  output logic                    trap_wb_o,
  output rv_pipe_pkg::trap_code_e trap_code_wb_o,
  output rv_isa_pkg::reg_idx_t    rd_wb_o,
  output rv_pipe_pkg::res_src_e   res_src_wb_o,
  output rv_isa_pkg::funct3_t     funct3_wb_o,
  output rv_isa_pkg::xlen_t       alu_result_wb_o,
  output rv_isa_pkg::xlen_t       pc_plus4_wb_o,
  output rv_isa_pkg::xlen_t       jb_tgt_wb_o,
  output rv_isa_pkg::xlen_t       ld_data_wb_o
);

  rv_isa_pkg::xlen_t ld_fmt_data;

  rv_wb_if wb_bus ();

  // Request port also fills the bundle's control bits
  rv_dmem_port rv_dmem_port_i (
    .valid_i     (valid_i),
    .mem_read_i  (mem_read_i),
    .mem_write_i (mem_write_i),
    .reg_write_i (reg_write_i),
    .trap_i      (trap_i),
    .trap_code_i (trap_code_i),
    .funct3_i    (funct3_i),
    .addr_i      (alu_result_i),
    .rs2_data_i  (rs2_data_i),
    .dmem_ren_o  (dmem_ren_o),
    .dmem_we_o   (dmem_we_o),
    .dmem_raddr_o(dmem_raddr_o),
    .dmem_waddr_o(dmem_waddr_o),
    .dmem_wdata_o(dmem_wdata_o),
    .dmem_wstrb_o(dmem_wstrb_o),
    .wb          (wb_bus)
  );

  // Same-cycle memory, so loads are formatted here
  rv_ld_fmt rv_ld_fmt_i (
    .rdata_i  (dmem_rdata_i),
    .addr_lo_i(alu_result_i[1:0]),
    .funct3_i (funct3_i),
    .data_o   (ld_fmt_data)
  );

  assign ld_data_mem_o = ld_fmt_data;

  // ==============================
  // Forwarded result
  // ==============================

  always_comb begin
    case (res_src_i)
      rv_pipe_pkg::RES_PC4: result_mem_o = pc_plus4_i;
      rv_pipe_pkg::RES_TGT: result_mem_o = jb_tgt_i;
      default:              result_mem_o = alu_result_i;
    endcase
  end

  // Payload side of the bundle
  assign wb_bus.rd         = rd_i;
  assign wb_bus.res_src    = res_src_i;
  assign wb_bus.funct3     = funct3_i;
  assign wb_bus.alu_result = alu_result_i;
  assign wb_bus.pc_plus4   = pc_plus4_i;
  assign wb_bus.jb_tgt     = jb_tgt_i;
  assign wb_bus.ld_data    = ld_fmt_data;

  rv_mem_wb_reg rv_mem_wb_reg_i (
    .clk            (clk),
    .rst_n          (rst_n),
    .valid_i        (valid_i),
    .stall_i        (stall_i),
    .wb             (wb_bus),
    .valid_o        (valid_o),
    .reg_write_wb_o (reg_write_wb_o),
    .trap_wb_o      (trap_wb_o),
    .trap_code_wb_o (trap_code_wb_o),
    .rd_wb_o        (rd_wb_o),
    .res_src_wb_o   (res_src_wb_o),
    .funct3_wb_o    (funct3_wb_o),
    .alu_result_wb_o(alu_result_wb_o),
    .pc_plus4_wb_o  (pc_plus4_wb_o),
    .jb_tgt_wb_o    (jb_tgt_wb_o),
    .ld_data_wb_o   (ld_data_wb_o)
  );

endmodule

/* tb_clk_gen.sv */
module tb_clk_gen (
  output logic clk_o,
  output logic rst_n_o
);

  timeunit 1ns;
  timeprecision 100ps;

  // 20 ns period
  initial begin
    clk_o = 1'b0;
    forever #10 clk_o = ~clk_o;
  end

  // Reset seen by three rising edges
  initial begin
    rst_n_o = 1'b0;
    repeat (3) @(posedge clk_o);
    rst_n_o <= 1'b1;
  end

endmodule

/* tb_rv_stage_mem.sv */
module tb_rv_stage_mem;

  timeunit 1ns;
  timeprecision 100ps;

  // One line of the vector file
  typedef struct packed {
    logic [5:0]           ctl;
    logic [1:0]           tc;
    logic [1:0]           rs;
    rv_isa_pkg::funct3_t  f3;
    rv_isa_pkg::reg_idx_t rd;
    rv_isa_pkg::xlen_t    alu;
    rv_isa_pkg::xlen_t    rs2;
    rv_isa_pkg::xlen_t    pc4;
    rv_isa_pkg::xlen_t    tgt;
    rv_isa_pkg::xlen_t    rdata;
    logic [1:0]           en;
    rv_isa_pkg::xlen_t    waddr;
    rv_isa_pkg::xlen_t    wdata;
    rv_isa_pkg::wstrb_t   wstrb;
    rv_isa_pkg::xlen_t    res;
    rv_isa_pkg::xlen_t    ld;
  } vec_t;

  // DUT ports, same names as the DUT for the .* hookup
  logic clk, rst_n, valid_i, stall_i, reg_write_i, mem_read_i, mem_write_i, trap_i;
  logic dmem_ren_o, dmem_we_o, valid_o, reg_write_wb_o, trap_wb_o;
  rv_pipe_pkg::trap_code_e trap_code_i, trap_code_wb_o;
  rv_pipe_pkg::res_src_e   res_src_i, res_src_wb_o;
  rv_isa_pkg::funct3_t     funct3_i, funct3_wb_o;
  rv_isa_pkg::reg_idx_t    rd_i, rd_wb_o;
  rv_isa_pkg::xlen_t       alu_result_i, rs2_data_i, pc_plus4_i, jb_tgt_i, dmem_rdata_i;
  rv_isa_pkg::xlen_t       dmem_raddr_o, dmem_waddr_o, dmem_wdata_o;
  rv_isa_pkg::xlen_t       result_mem_o, ld_data_mem_o;
  rv_isa_pkg::xlen_t       alu_result_wb_o, pc_plus4_wb_o, jb_tgt_wb_o, ld_data_wb_o;
  rv_isa_pkg::wstrb_t      dmem_wstrb_o;

  vec_t   vecs[$];
  bit     loaded = 1'b0;
  integer seed;

  // Expected MEM/WB contents
  logic                    m_valid = 1'b0;
  logic                    m_rw = 1'b0;
  logic                    m_trap = 1'b0;
  rv_pipe_pkg::trap_code_e m_code;
  rv_isa_pkg::reg_idx_t    m_rd;
  rv_pipe_pkg::res_src_e   m_src;
  rv_isa_pkg::funct3_t     m_f3;
  rv_isa_pkg::xlen_t       m_alu, m_pc4, m_tgt, m_ld;

  tb_clk_gen clk_gen_i (
    .clk_o  (clk),
    .rst_n_o(rst_n)
  );

  rv_stage_mem rv_stage_mem_i (.*);

  // ==============================
  // Failure and compare tasks
  // ==============================

  task automatic abort_run();
    $display("Test failed");
    $fatal(1, "Run stopped at first error");
  endtask

  task automatic check_word(input string what, input rv_isa_pkg::xlen_t got,
                            input rv_isa_pkg::xlen_t exp);
    if (got !== exp) begin
      $display("Mismatch at %0t ns: %s is %h, expected %h", $time, what, got, exp);
      abort_run();
    end
  endtask

  task automatic check_strb(input string what, input rv_isa_pkg::wstrb_t got,
                            input rv_isa_pkg::wstrb_t exp);
    if (got !== exp) begin
      $display("Mismatch at %0t ns: %s is %b, expected %b", $time, what, got, exp);
      abort_run();
    end
  endtask

  task automatic check_code(input string what, input rv_pipe_pkg::trap_code_e got,
                            input rv_pipe_pkg::trap_code_e exp);
    if (got !== exp) begin
      $display("Mismatch at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
      abort_run();
    end
  endtask

  task automatic check_idx(input string what, input rv_isa_pkg::reg_idx_t got,
                           input rv_isa_pkg::reg_idx_t exp);
    if (got !== exp) begin
      $display("Mismatch at %0t ns: %s is %h, expected %h", $time, what, got, exp);
      abort_run();
    end
  endtask

  task automatic check_src(input string what, input rv_pipe_pkg::res_src_e got,
                           input rv_pipe_pkg::res_src_e exp);
    if (got !== exp) begin
      $display("Mismatch at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
      abort_run();
    end
  endtask

  task automatic check_f3(input string what, input rv_isa_pkg::funct3_t got,
                          input rv_isa_pkg::funct3_t exp);
    if (got !== exp) begin
      $display("Mismatch at %0t ns: %s is %b, expected %b", $time, what, got, exp);
      abort_run();
    end
  endtask

  task automatic check_bit(input string what, input logic got, input logic exp);
    if (got !== exp) begin
      $display("Mismatch at %0t ns: %s is %b, expected %b", $time, what, got, exp);
      abort_run();
    end
  endtask

  // ==============================
  // Reference rules
  // ==============================

  function automatic int size_bytes(input rv_isa_pkg::funct3_t f3);
    case (f3[1:0])
      rv_isa_pkg::SIZE_BYTE: return 1;
      rv_isa_pkg::SIZE_HALF: return 2;
      default:               return 4;
    endcase
  endfunction

  // Each lane repeats the access-sized chunk
  function automatic rv_isa_pkg::xlen_t exp_store_data(input rv_isa_pkg::funct3_t f3,
                                                       input rv_isa_pkg::xlen_t d);
    rv_isa_pkg::xlen_t w;
    int n;
    int i;
    n = size_bytes(f3);
    for (i = 0; i < 4; i++) w[8*i +: 8] = d[8*(i % n) +: 8];
    return w;
  endfunction

  // Lanes from the size-aligned base up to base plus size
  function automatic rv_isa_pkg::wstrb_t exp_strobe(input rv_isa_pkg::funct3_t f3,
                                                    input logic [1:0] off);
    rv_isa_pkg::wstrb_t s;
    int n;
    int base;
    int i;
    n    = size_bytes(f3);
    base = (int'(off) / n) * n;
    for (i = 0; i < 4; i++) s[i] = (i >= base) && (i < base + n);
    return s;
  endfunction

  function automatic rv_isa_pkg::xlen_t exp_load(input rv_isa_pkg::funct3_t f3,
                                                 input logic [1:0] off,
                                                 input rv_isa_pkg::xlen_t rdata);
    rv_isa_pkg::xlen_t sh;
    rv_isa_pkg::xlen_t mask;
    int n;
    int base;
    n = size_bytes(f3);
    if (n == 4) return rdata;
    base = (int'(off) / n) * n;
    sh   = rdata >> (8 * base);
    mask = (32'h1 << (8 * n)) - 32'h1;
    // Fill upper bits with the top data bit unless unsigned
    if (!f3[rv_isa_pkg::LD_UNSIGNED_BIT] && sh[8*n-1]) return (sh & mask) | ~mask;
    return sh & mask;
  endfunction

  // ==============================
  // Vectors
  // ==============================

  task automatic load_vectors();
    int fd;
    int n;
    string line;
    vec_t v;
    logic [5:0] ctl;
    logic [1:0] tc, rs, en;
    rv_isa_pkg::funct3_t f3;
    rv_isa_pkg::reg_idx_t rd;
    rv_isa_pkg::wstrb_t wstrb;
    rv_isa_pkg::xlen_t alu, rs2, pc4, tgt, rdata, waddr, wdata, res, ld;
    fd = $fopen("rv_mem_stimulus.txt", "r");
    if (fd == 0) begin
      $display("Could not open rv_mem_stimulus.txt for reading");
      abort_run();
    end
    while (!$feof(fd)) begin
      n = $fgets(line, fd);
      // 8'h23 marks a comment line
      if (n > 0 && line.getc(0) != 8'h23) begin
        n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                    ctl, tc, rs, f3, rd, alu, rs2, pc4, tgt, rdata,
                    en, waddr, wdata, wstrb, res, ld);
        if (n == 16) begin
          v = {ctl, tc, rs, f3, rd, alu, rs2, pc4, tgt, rdata, en, waddr, wdata, wstrb, res, ld};
          vecs.push_back(v);
        end
      end
    end
    $fclose(fd);
    if (vecs.size() == 0) begin
      $display("No usable vectors in rv_mem_stimulus.txt");
      abort_run();
    end
  endtask

  // Aligned loads and stores, expected values from the rules above
  task automatic add_random_vectors();
    vec_t v;
    logic [31:0] r;
    logic store;
    logic [2:0] pick;
    int i;
    for (i = 0; i < 40; i++) begin
      r     = $random(seed);
      store = r[0];
      pick  = r[10:8] % 3'd5;
      if (store) begin
        v.f3 = {1'b0, r[5:4] % 2'd3};
      end else begin
        case (pick)
          3'd0:    v.f3 = 3'd0;
          3'd1:    v.f3 = 3'd1;
          3'd2:    v.f3 = 3'd2;
          3'd3:    v.f3 = 3'd4;
          default: v.f3 = 3'd5;
        endcase
      end
      v.alu = $random(seed);
      if (v.f3[1:0] == rv_isa_pkg::SIZE_HALF) v.alu[0] = 1'b0;
      if (v.f3[1:0] == rv_isa_pkg::SIZE_WORD) v.alu[1:0] = 2'b00;
      v.rs2   = $random(seed);
      v.pc4   = $random(seed);
      v.tgt   = $random(seed);
      v.rdata = $random(seed);
      v.rd    = r[20:16];
      v.rs    = r[13:12] % 2'd3;
      v.tc    = 2'b00;
      v.ctl   = {1'b1, 1'b0, !store, !store, store, 1'b0};
      v.en    = {!store, store};
      v.waddr = {v.alu[31:2], 2'b00};
      v.wdata = exp_store_data(v.f3, v.rs2);
      v.wstrb = store ? exp_strobe(v.f3, v.alu[1:0]) : 4'b0000;
      case (v.rs)
        2'd1:    v.res = v.pc4;
        2'd2:    v.res = v.tgt;
        default: v.res = v.alu;
      endcase
      v.ld = exp_load(v.f3, v.alu[1:0], v.rdata);
      vecs.push_back(v);
    end
  endtask

  task automatic drive(input vec_t v);
    valid_i      <= v.ctl[5];
    stall_i      <= v.ctl[4];
    reg_write_i  <= v.ctl[3];
    mem_read_i   <= v.ctl[2];
    mem_write_i  <= v.ctl[1];
    trap_i       <= v.ctl[0];
    trap_code_i  <= rv_pipe_pkg::trap_code_e'(v.tc);
    res_src_i    <= rv_pipe_pkg::res_src_e'(v.rs);
    funct3_i     <= v.f3;
    rd_i         <= v.rd;
    alu_result_i <= v.alu;
    rs2_data_i   <= v.rs2;
    pc_plus4_i   <= v.pc4;
    jb_tgt_i     <= v.tgt;
    dmem_rdata_i <= v.rdata;
  endtask

  // Same-cycle outputs
  task automatic check_comb(input vec_t v);
    check_bit("dmem_ren_o", dmem_ren_o, v.en[1]);
    check_bit("dmem_we_o", dmem_we_o, v.en[0]);
    check_word("dmem_raddr_o", dmem_raddr_o, v.waddr);
    check_word("dmem_waddr_o", dmem_waddr_o, v.waddr);
    check_word("dmem_wdata_o", dmem_wdata_o, v.wdata);
    check_strb("dmem_wstrb_o", dmem_wstrb_o, v.wstrb);
    check_word("result_mem_o", result_mem_o, v.res);
    check_word("ld_data_mem_o", ld_data_mem_o, v.ld);
  endtask

  // Payload may be stale after a bubble
  task automatic check_wb();
    check_bit("valid_o", valid_o, m_valid);
    check_bit("reg_write_wb_o", reg_write_wb_o, m_rw);
    check_bit("trap_wb_o", trap_wb_o, m_trap);
    if (m_valid) begin
      check_code("trap_code_wb_o", trap_code_wb_o, m_code);
      check_idx("rd_wb_o", rd_wb_o, m_rd);
      check_src("res_src_wb_o", res_src_wb_o, m_src);
      check_f3("funct3_wb_o", funct3_wb_o, m_f3);
      check_word("alu_result_wb_o", alu_result_wb_o, m_alu);
      check_word("pc_plus4_wb_o", pc_plus4_wb_o, m_pc4);
      check_word("jb_tgt_wb_o", jb_tgt_wb_o, m_tgt);
      check_word("ld_data_wb_o", ld_data_wb_o, m_ld);
    end
  endtask

  // What the next unstalled edge puts into MEM/WB
  task automatic update_model(input vec_t v);
    logic mis;
    logic trap_all;
    mis = (v.ctl[2] || v.ctl[1]) &&
          ((v.f3[1:0] == rv_isa_pkg::SIZE_HALF && v.alu[0]) ||
           (v.f3[1:0] == rv_isa_pkg::SIZE_WORD && v.alu[1:0] != 2'b00));
    trap_all = v.ctl[0] || mis;
    if (!v.ctl[4]) begin
      m_valid = v.ctl[5];
      m_rw    = v.ctl[5] && v.ctl[3] && !trap_all;
      m_trap  = v.ctl[5] && trap_all;
      m_code  = mis ? rv_pipe_pkg::TRAP_LDST_MISALIGN : rv_pipe_pkg::trap_code_e'(v.tc);
      m_rd    = v.rd;
      m_src   = rv_pipe_pkg::res_src_e'(v.rs);
      m_f3    = v.f3;
      m_alu   = v.alu;
      m_pc4   = v.pc4;
      m_tgt   = v.tgt;
      m_ld    = v.ld;
    end
  endtask

  // ==============================
  // Run
  // ==============================

  initial begin
    int k;
    seed = 32'ha6c;
    drive('0);
    load_vectors();
    add_random_vectors();
    loaded = 1'b1;
    wait (rst_n === 1'b1);
    // Drive on the rising edge, check at the falling edge
    for (k = 0; k < vecs.size(); k++) begin
      @(posedge clk);
      drive(vecs[k]);
      @(negedge clk);
      check_comb(vecs[k]);
      check_wb();
      update_model(vecs[k]);
    end
    // Last vector reaches MEM/WB
    @(posedge clk);
    @(negedge clk);
    check_wb();
    $display("Test completed successfully");
    $finish;
  end

  // Vector count plus 50 cycles of margin
  initial begin
    wait (loaded);
    #((vecs.size() + 50) * 20);
    $display("Timeout, the run did not finish within %0d cycles", vecs.size() + 50);
    abort_run();
  end

endmodule

/* rv_mem_stimulus.txt */
# hex: ctl tc rs f3 rd alu rs2 pc4 tgt rdata | en waddr wdata wstrb result_mem ld_data_mem
# ctl = {valid, stall, reg_write, mem_read, mem_write, trap}, en = {ren, we}
22 0 0 0 00 00000100 a1b2c3d4 00001004 00002000 80f17f9c 1 00000100 d4d4d4d4 1 00000100 ffffff9c
22 0 0 0 00 00000101 a1b2c3d4 00001004 00002000 80f17f9c 1 00000100 d4d4d4d4 2 00000101 0000007f
22 0 0 0 00 00000102 a1b2c3d4 00001004 00002000 80f17f9c 1 00000100 d4d4d4d4 4 00000102 fffffff1
22 0 0 0 00 00000103 a1b2c3d4 00001004 00002000 80f17f9c 1 00000100 d4d4d4d4 8 00000103 ffffff80
22 0 0 1 00 00000104 a1b2c3d4 00001004 00002000 80f17f9c 1 00000104 c3d4c3d4 3 00000104 00007f9c
22 0 0 1 00 00000106 a1b2c3d4 00001004 00002000 80f17f9c 1 00000104 c3d4c3d4 c 00000106 ffff80f1
22 0 0 2 00 00000108 a1b2c3d4 00001004 00002000 80f17f9c 1 00000108 a1b2c3d4 f 00000108 80f17f9c
2c 0 0 0 05 00000201 a1b2c3d4 00001004 00002000 80f17f9c 2 00000200 d4d4d4d4 0 00000201 0000007f
2c 0 0 4 06 00000200 a1b2c3d4 00001004 00002000 80f17f9c 2 00000200 d4d4d4d4 0 00000200 0000009c
2c 0 0 4 07 00000203 a1b2c3d4 00001004 00002000 80f17f9c 2 00000200 d4d4d4d4 0 00000203 00000080
2c 0 0 1 08 00000202 a1b2c3d4 00001004 00002000 80f17f9c 2 00000200 c3d4c3d4 0 00000202 ffff80f1
2c 0 0 5 09 00000206 a1b2c3d4 00001004 00002000 80f17f9c 2 00000204 c3d4c3d4 0 00000206 000080f1
2c 0 0 2 0a 00000208 a1b2c3d4 00001004 00002000 80f17f9c 2 00000208 a1b2c3d4 0 00000208 80f17f9c
2c 0 0 1 0b 00000301 a1b2c3d4 00001004 00002000 80f17f9c 0 00000300 c3d4c3d4 0 00000301 00007f9c
22 0 0 2 00 00000302 a1b2c3d4 00001004 00002000 80f17f9c 0 00000300 a1b2c3d4 f 00000302 80f17f9c
2d 1 0 2 0c 00000304 a1b2c3d4 00001004 00002000 80f17f9c 0 00000304 a1b2c3d4 0 00000304 80f17f9c
28 0 1 0 01 00000400 a1b2c3d4 00001004 00002000 80f17f9c 0 00000400 d4d4d4d4 0 00001004 ffffff9c
28 0 2 0 02 00000404 a1b2c3d4 00001004 00002000 80f17f9c 0 00000404 d4d4d4d4 0 00002000 ffffff9c
38 0 0 0 03 00000500 a1b2c3d4 00001004 00002000 80f17f9c 0 00000500 d4d4d4d4 0 00000500 ffffff9c
10 0 0 0 00 00000504 a1b2c3d4 00001004 00002000 80f17f9c 0 00000504 d4d4d4d4 0 00000504 ffffff9c
00 0 0 0 00 00000508 a1b2c3d4 00001004 00002000 80f17f9c 0 00000508 d4d4d4d4 0 00000508 ffffff9c
3c 0 0 2 0d 00000510 a1b2c3d4 00001004 00002000 80f17f9c 2 00000510 a1b2c3d4 0 00000510 80f17f9c
2c 0 0 2 0d 00000510 a1b2c3d4 00001004 00002000 80f17f9c 2 00000510 a1b2c3d4 0 00000510 80f17f9c

/* list.f */
rv_isa_pkg.sv
rv_pipe_pkg.sv
rv_wb_if.sv
rv_st_fmt.sv
rv_ld_fmt.sv
rv_dmem_port.sv
rv_mem_wb_reg.sv
rv_stage_mem.sv
tb_clk_gen.sv
tb_rv_stage_mem.sv

/* run.sh */
#!/bin/sh
# Build and run the MEM stage testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/100ps \
  --top-module tb_rv_stage_mem -f list.f -o Vtb_rv_stage_mem
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/Vtb_rv_stage_mem > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "Test failed" "$LOG"; then
  exit 1
fi
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi
exit 0
